//--- sources.f
+incdir+tests
rtl/vga_timing_pkg.sv
rtl/draw_pkg.sv
rtl/vga_sync.sv
rtl/draw_cmd_decode.sv
rtl/rect_compose.sv
rtl/pixel_out.sv
rtl/vga_rect_top.sv
tests/tb_vga_rect_top.sv

//--- Makefile
SIM := obj_dir/Vtb_vga_rect_top

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard rtl/*.sv tests/*.sv tests/*.svh)
	verilator --binary --timing -j 0 --top-module tb_vga_rect_top -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TESTBENCH PASSED'

clean:
	rm -rf obj_dir

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// *******************************************************************
// reference raster counted in the same ticks as the display
// *******************************************************************

localparam logic [COORD_W-1:0] H_LAST  = COORD_W'(H_DISPLAY + H_FRONT + H_BACK + H_RETRACE - 1);
localparam logic [COORD_W-1:0] V_LAST  = COORD_W'(V_DISPLAY + V_FRONT + V_BACK + V_RETRACE - 1);
localparam logic [COORD_W-1:0] H_SYNC0 = COORD_W'(H_DISPLAY + H_FRONT);
localparam logic [COORD_W-1:0] H_SYNC1 = COORD_W'(H_DISPLAY + H_FRONT + H_RETRACE);
localparam logic [COORD_W-1:0] V_SYNC0 = COORD_W'(V_DISPLAY + V_FRONT);
localparam logic [COORD_W-1:0] V_SYNC1 = COORD_W'(V_DISPLAY + V_FRONT + V_RETRACE);
localparam logic [COORD_W-1:0] H_VIS   = COORD_W'(H_DISPLAY);
localparam logic [COORD_W-1:0] V_VIS   = COORD_W'(V_DISPLAY);

typedef struct packed
{
   draw_op_t           op;
   logic [IDX_W-1:0]   idx;
   logic [COORD_W-1:0] x0;
   logic [COORD_W-1:0] y0;
   logic [COORD_W-1:0] x1;
   logic [COORD_W-1:0] y1;
   logic [COLOR_W-1:0] color;
} cmd_t;

logic               m_tick;
logic [COORD_W-1:0] m_hc;
logic [COORD_W-1:0] m_vc;
logic               rst_seen = 1'b1;
int                 run_len = 0;
int                 frame_count = 0;
int                 num_checks = 0;
int                 lit_pixels = 0;
logic               acc_next = 1'b0;
cmd_t               nx_cmd;
cmd_t               m_cmd;
logic               m_pend;
// expected {hsync, vsync, rgb}, newest first
logic [COLOR_W+1:0] pipe [3];

// rectangle table as the display sees it
logic               m_en    [NUM_RECTS];
logic [COORD_W-1:0] m_x0    [NUM_RECTS];
logic [COORD_W-1:0] m_y0    [NUM_RECTS];
logic [COORD_W-1:0] m_x1    [NUM_RECTS];
logic [COORD_W-1:0] m_y1    [NUM_RECTS];
logic [COLOR_W-1:0] m_color [NUM_RECTS];
logic [COLOR_W-1:0] m_bg;

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
   num_checks++;
   if (actual !== expected)
   begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      $display("TESTBENCH FAILED");
      $fatal(1);
   end
endtask

// lowest enabled slot that covers the pixel or else the background
function automatic logic [COLOR_W-1:0] model_color(input logic [COORD_W-1:0] x,
                                                   input logic [COORD_W-1:0] y);
   logic [COLOR_W-1:0] c;
   logic               found;
   c     = m_bg;
   found = 1'b0;
   for (int i = 0; i < NUM_RECTS; i++)
   begin
      if (!found && m_en[i] && (x >= m_x0[i]) && (x <= m_x1[i]) &&
          (y >= m_y0[i]) && (y <= m_y1[i]))
      begin
         c     = m_color[i];
         found = 1'b1;
      end
   end
   return c;
endfunction

task automatic commit_command();
   case (m_cmd.op)
      OP_SET_RECT:
      begin
         m_en[m_cmd.idx]    = 1'b1;
         m_x0[m_cmd.idx]    = m_cmd.x0;
         m_y0[m_cmd.idx]    = m_cmd.y0;
         m_x1[m_cmd.idx]    = m_cmd.x1;
         m_y1[m_cmd.idx]    = m_cmd.y1;
         m_color[m_cmd.idx] = m_cmd.color;
      end
      OP_SET_BG:
         m_bg = m_cmd.color;
      OP_DISABLE_RECT:
         m_en[m_cmd.idx] = 1'b0;
      default:
         ;
   endcase
endtask

// *******************************************************************
// one model step per clock at the falling edge
// *******************************************************************

task automatic model_step();
   logic [COLOR_W+1:0] want;
   logic [COLOR_W+1:0] now;
   logic               vis;
   if (rst_seen)
   begin
      m_tick  = 1'b1;
      m_hc    = '0;
      m_vc    = '0;
      m_pend  = 1'b0;
      m_bg    = '0;
      run_len = 0;
      for (int i = 0; i < NUM_RECTS; i++)
         m_en[i] = 1'b0;
   end
   else
   begin
      // frame boundary on the edge that just passed
      if (m_tick && (m_hc == H_LAST) && (m_vc == V_LAST))
      begin
         frame_count++;
         if (m_pend)
            commit_command();
         m_pend = 1'b0;
      end
      if (acc_next)
      begin
         m_cmd  = nx_cmd;
         m_pend = 1'b1;
      end
      if (m_tick)
      begin
         if (m_hc == H_LAST)
         begin
            m_hc = '0;
            m_vc = (m_vc == V_LAST) ? '0 : m_vc + 1'b1;
         end
         else
            m_hc = m_hc + 1'b1;
      end
      m_tick = ~m_tick;
      if (run_len < 3)
         run_len++;
   end
   rst_seen = reset;

   want = (run_len >= 3) ? pipe[2] : '0;
   check_value("hsync", 32'(hsync), 32'(want[COLOR_W+1]));
   check_value("vsync", 32'(vsync), 32'(want[COLOR_W]));
   check_value("rgb", 32'(rgb), 32'(want[COLOR_W-1:0]));
   check_value("p_tick", 32'(p_tick), 32'(m_tick));
   check_value("cmd_ready", 32'(cmd_ready), 32'(!m_pend));
   if (rgb != '0)
      lit_pixels++;

   vis = (m_hc < H_VIS) && (m_vc < V_VIS);
   now = {(m_hc >= H_SYNC0) && (m_hc < H_SYNC1),
          (m_vc >= V_SYNC0) && (m_vc < V_SYNC1),
          vis ? model_color(m_hc, m_vc) : COLOR_W'(0)};
   pipe[2] = pipe[1];
   pipe[1] = pipe[0];
   pipe[0] = now;

   // a transfer happens on the next rising edge
   acc_next = cmd_valid && cmd_ready;
   nx_cmd   = '{cmd_op, cmd_index, cmd_x0, cmd_y0, cmd_x1, cmd_y1, cmd_color};
endtask

`endif

//--- tests/tb_vga_rect_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vga_rect_top
   import vga_timing_pkg::*;
   import draw_pkg::*;
   ();

   localparam int H_DISPLAY = 32;
   localparam int H_FRONT   = 4;
   localparam int H_BACK    = 4;
   localparam int H_RETRACE = 4;
   localparam int V_DISPLAY = 12;
   localparam int V_FRONT   = 2;
   localparam int V_BACK    = 2;
   localparam int V_RETRACE = 2;
   localparam int NUM_RECTS = 4;
   localparam int IDX_W     = $clog2(NUM_RECTS);
   // two clocks per pixel tick
   localparam int FRAME_CLKS = 2 * (H_DISPLAY + H_FRONT + H_BACK + H_RETRACE) *
                               (V_DISPLAY + V_FRONT + V_BACK + V_RETRACE);
   localparam int TIMEOUT_CYCLES = FRAME_CLKS * 20 * 3 / 2;

   logic               clk       = 1'b0;
   logic               reset     = 1'b1;
   logic               cmd_valid = 1'b0;
   wire                cmd_ready;
   draw_op_t           cmd_op    = OP_SET_RECT;
   logic [IDX_W-1:0]   cmd_index = '0;
   logic [COORD_W-1:0] cmd_x0    = '0;
   logic [COORD_W-1:0] cmd_y0    = '0;
   logic [COORD_W-1:0] cmd_x1    = '0;
   logic [COORD_W-1:0] cmd_y1    = '0;
   logic [COLOR_W-1:0] cmd_color = '0;
   wire                hsync;
   wire                vsync;
   wire  [COLOR_W-1:0] rgb;
   wire                p_tick;
   int                 cycles = 0;

   `include "tb_model.svh"

   vga_rect_top #(
      .H_DISPLAY (H_DISPLAY), .H_FRONT (H_FRONT), .H_BACK (H_BACK), .H_RETRACE (H_RETRACE),
      .V_DISPLAY (V_DISPLAY), .V_FRONT (V_FRONT), .V_BACK (V_BACK), .V_RETRACE (V_RETRACE),
      .NUM_RECTS (NUM_RECTS)
   ) dut (
      .clk, .reset, .cmd_valid, .cmd_ready, .cmd_op, .cmd_index,
      .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_color,
      .hsync, .vsync, .rgb, .p_tick
   );

   initial
   begin
      forever #20 clk = ~clk;
   end

   always @(negedge clk)
      model_step();

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, the command port stopped making progress", cycles);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   end

   function automatic draw_op_t random_op();
      case ($urandom % 4)
         0, 1:    return OP_SET_RECT;
         2:       return OP_SET_BG;
         default: return OP_DISABLE_RECT;
      endcase
   endfunction

   // random corners that are now and then inverted so the slot never hits
   task automatic load_fields(input draw_op_t op, input int idx);
      logic [COORD_W-1:0] xa;
      logic [COORD_W-1:0] xb;
      logic [COORD_W-1:0] ya;
      logic [COORD_W-1:0] yb;
      xa = COORD_W'($urandom % 36);
      xb = xa + COORD_W'($urandom % 20);
      ya = COORD_W'($urandom % 14);
      yb = ya + COORD_W'($urandom % 8);
      cmd_op    <= op;
      cmd_index <= IDX_W'(idx);
      cmd_y0    <= ya;
      cmd_y1    <= yb;
      cmd_color <= COLOR_W'($urandom % 4095 + 1);
      if ($urandom % 8 == 0)
      begin
         cmd_x0 <= xb;
         cmd_x1 <= xa;
      end
      else
      begin
         cmd_x0 <= xa;
         cmd_x1 <= xb;
      end
   endtask

   // returns on the rising edge that transfers the command
   task automatic wait_accept();
      do
         @(negedge clk);
      while (!cmd_ready);
      @(posedge clk);
   endtask

   task automatic wait_ready();
      do
         @(negedge clk);
      while (!cmd_ready);
   endtask

   task automatic wait_frames(input int n);
      int target;
      target = frame_count + n;
      while (frame_count < target)
         @(negedge clk);
   endtask

   task automatic send_command(input draw_op_t op, input int idx);
      @(posedge clk);
      load_fields(op, idx);
      cmd_valid <= 1'b1;
      wait_accept();
      cmd_valid <= 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'h7ac5));
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // idle frames with sync pulses only and a black screen
      wait_frames(2);

      send_command(OP_SET_BG, 0);
      wait_ready();
      wait_frames(1);

      // overlapping rectangles in every slot
      for (int k = 0; k < NUM_RECTS; k++)
         send_command(OP_SET_RECT, k);
      wait_ready();
      wait_frames(1);

      send_command(OP_DISABLE_RECT, $urandom % NUM_RECTS);
      wait_ready();
      wait_frames(1);

      // *******************************************************************
      // back-pressure with valid held high across several commands
      // *******************************************************************
      @(posedge clk);
      load_fields(random_op(), $urandom % NUM_RECTS);
      cmd_valid <= 1'b1;
      for (int k = 0; k < 5; k++)
      begin
         wait_accept();
         if (k < 4)
            load_fields(random_op(), $urandom % NUM_RECTS);
         else
            cmd_valid <= 1'b0;
      end
      wait_ready();
      wait_frames(2);

      if ((num_checks == 0) || (lit_pixels == 0))
      begin
         $display("no visible pixel was ever lit, so the colour path went unchecked");
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
      else
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- rtl/vga_rect_top.sv
`timescale 1ns/100ps
`default_nettype none

module vga_rect_top
   import vga_timing_pkg::*;
   import draw_pkg::*;
   #(
      parameter int H_DISPLAY = H_DISPLAY_640,
      parameter int H_FRONT   = H_FRONT_640,
      parameter int H_BACK    = H_BACK_640,
      parameter int H_RETRACE = H_RETRACE_640,
      parameter int V_DISPLAY = V_DISPLAY_480,
      parameter int V_FRONT   = V_FRONT_480,
      parameter int V_BACK    = V_BACK_480,
      parameter int V_RETRACE = V_RETRACE_480,
      parameter int NUM_RECTS = DEFAULT_NUM_RECTS,
      localparam int IDX_W    = (NUM_RECTS > 1) ? $clog2(NUM_RECTS) : 1
   )
   (
      input  wire                clk,
      input  wire                reset,
      input  wire                cmd_valid,
      output wire                cmd_ready,
      input  wire draw_op_t      cmd_op,
      input  wire [IDX_W-1:0]    cmd_index,
      input  wire [COORD_W-1:0]  cmd_x0,
      input  wire [COORD_W-1:0]  cmd_y0,
      input  wire [COORD_W-1:0]  cmd_x1,
      input  wire [COORD_W-1:0]  cmd_y1,
      input  wire [COLOR_W-1:0]  cmd_color,
      output wire                hsync,
      output wire                vsync,
      output wire [COLOR_W-1:0]  rgb,
      output wire                p_tick
   );

   wire [COORD_W-1:0]                 pixel_x;
   wire [COORD_W-1:0]                 pixel_y;
   wire                               video_on;
   wire                               frame_start;
   wire                               hsync_raw;
   wire                               vsync_raw;
   wire [NUM_RECTS-1:0]               rect_en;
   wire [NUM_RECTS-1:0][COORD_W-1:0]  rect_x0;
   wire [NUM_RECTS-1:0][COORD_W-1:0]  rect_y0;
   wire [NUM_RECTS-1:0][COORD_W-1:0]  rect_x1;
   wire [NUM_RECTS-1:0][COORD_W-1:0]  rect_y1;
   wire [NUM_RECTS-1:0][COLOR_W-1:0]  rect_color;
   wire [COLOR_W-1:0]                 bg_color;
   wire [COLOR_W-1:0]                 pix_color;

   vga_sync #(
      .H_DISPLAY (H_DISPLAY), .H_FRONT (H_FRONT), .H_BACK (H_BACK), .H_RETRACE (H_RETRACE),
      .V_DISPLAY (V_DISPLAY), .V_FRONT (V_FRONT), .V_BACK (V_BACK), .V_RETRACE (V_RETRACE)
   ) u_sync (
      .clk, .reset, .hsync_raw, .vsync_raw, .video_on, .p_tick, .frame_start,
      .pixel_x, .pixel_y
   );

   draw_cmd_decode #(.NUM_RECTS (NUM_RECTS)) u_decode (
      .clk, .reset, .cmd_valid, .cmd_ready, .cmd_op, .cmd_index,
      .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_color, .frame_start,
      .rect_en, .rect_x0, .rect_y0, .rect_x1, .rect_y1, .rect_color, .bg_color
   );

   rect_compose #(.NUM_RECTS (NUM_RECTS)) u_compose (
      .clk, .reset, .pixel_x, .pixel_y, .video_on,
      .rect_en, .rect_x0, .rect_y0, .rect_x1, .rect_y1, .rect_color, .bg_color,
      .pix_color
   );

   pixel_out u_out (
      .clk, .reset, .pix_color, .video_on, .hsync_raw, .vsync_raw,
      .rgb, .hsync, .vsync
   );

endmodule

`default_nettype wire

//--- rtl/pixel_out.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_out
   import draw_pkg::*;
   (
      input  wire                clk,
      input  wire                reset,
      input  wire [COLOR_W-1:0]  pix_color,
      input  wire                video_on,
      input  wire                hsync_raw,
      input  wire                vsync_raw,
      output logic [COLOR_W-1:0] rgb,
      output logic               hsync,
      output logic               vsync
   );

   logic vid_d1;
   logic vid_d2;
   logic hsync_d1;
   logic vsync_d1;

   // *******************************************************************
   // alignment to the two-stage colour pipeline
   // *******************************************************************

   // video_on is combinational off the counters, sync is already one late
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         vid_d1   <= 1'b0;
         vid_d2   <= 1'b0;
         hsync_d1 <= 1'b0;
         vsync_d1 <= 1'b0;
         rgb      <= '0;
         hsync    <= 1'b0;
         vsync    <= 1'b0;
      end
      else
      begin
         vid_d1   <= video_on;
         vid_d2   <= vid_d1;
         hsync_d1 <= hsync_raw;
         vsync_d1 <= vsync_raw;
         // output registers
         rgb      <= vid_d2 ? pix_color : '0;
         hsync    <= hsync_d1;
         vsync    <= vsync_d1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/rect_compose.sv
`timescale 1ns/100ps
`default_nettype none

module rect_compose
   import vga_timing_pkg::*;
   import draw_pkg::*;
   #(
      parameter int NUM_RECTS = DEFAULT_NUM_RECTS
   )
   (
      input  wire                                clk,
      input  wire                                reset,
      input  wire [COORD_W-1:0]                  pixel_x,
      input  wire [COORD_W-1:0]                  pixel_y,
      input  wire                                video_on,
      input  wire [NUM_RECTS-1:0]                rect_en,
      input  wire [NUM_RECTS-1:0][COORD_W-1:0]   rect_x0,
      input  wire [NUM_RECTS-1:0][COORD_W-1:0]   rect_y0,
      input  wire [NUM_RECTS-1:0][COORD_W-1:0]   rect_x1,
      input  wire [NUM_RECTS-1:0][COORD_W-1:0]   rect_y1,
      input  wire [NUM_RECTS-1:0][COLOR_W-1:0]   rect_color,
      input  wire [COLOR_W-1:0]                  bg_color,
      output logic [COLOR_W-1:0]                 pix_color
   );

   logic [NUM_RECTS-1:0] hit_next;
   logic [NUM_RECTS-1:0] hit_s1;
   logic                 vid_s1;
   logic [COLOR_W-1:0]   color_next;

   // *******************************************************************
   // stage 1: hit test against every slot in parallel
   // *******************************************************************

   // inverted corners fail one of the compares, so they never hit
   always_comb
   begin
      for (int i = 0; i < NUM_RECTS; i++)
      begin
         hit_next[i] = rect_en[i] &&
                       (pixel_x >= rect_x0[i]) && (pixel_x <= rect_x1[i]) &&
                       (pixel_y >= rect_y0[i]) && (pixel_y <= rect_y1[i]);
      end
   end

   // *******************************************************************
   // stage 2: priority select, lowest index wins
   // *******************************************************************

   // walk from the top slot down so the lowest hit is assigned last
   always_comb
   begin
      color_next = bg_color;
      for (int i = NUM_RECTS - 1; i >= 0; i--)
      begin
         if (hit_s1[i])
            color_next = rect_color[i];
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         hit_s1    <= '0;
         vid_s1    <= 1'b0;
         pix_color <= '0;
      end
      else
      begin
         hit_s1    <= hit_next;
         vid_s1    <= video_on;
         // hold the colour at zero through blanking
         pix_color <= vid_s1 ? color_next : '0;
      end
   end

endmodule

`default_nettype wire

//--- rtl/draw_cmd_decode.sv
`timescale 1ns/100ps
`default_nettype none

module draw_cmd_decode
   import vga_timing_pkg::*;
   import draw_pkg::*;
   #(
      parameter int NUM_RECTS = DEFAULT_NUM_RECTS,
      localparam int IDX_W    = (NUM_RECTS > 1) ? $clog2(NUM_RECTS) : 1
   )
   (
      input  wire                                clk,
      input  wire                                reset,
      input  wire                                cmd_valid,
      output logic                               cmd_ready,
      input  wire draw_op_t                      cmd_op,
      input  wire [IDX_W-1:0]                    cmd_index,
      input  wire [COORD_W-1:0]                  cmd_x0,
      input  wire [COORD_W-1:0]                  cmd_y0,
      input  wire [COORD_W-1:0]                  cmd_x1,
      input  wire [COORD_W-1:0]                  cmd_y1,
      input  wire [COLOR_W-1:0]                  cmd_color,
      input  wire                                frame_start,
      output logic [NUM_RECTS-1:0]               rect_en,
      output logic [NUM_RECTS-1:0][COORD_W-1:0]  rect_x0,
      output logic [NUM_RECTS-1:0][COORD_W-1:0]  rect_y0,
      output logic [NUM_RECTS-1:0][COORD_W-1:0]  rect_x1,
      output logic [NUM_RECTS-1:0][COORD_W-1:0]  rect_y1,
      output logic [NUM_RECTS-1:0][COLOR_W-1:0]  rect_color,
      output logic [COLOR_W-1:0]                 bg_color
   );

   logic               pend_valid;
   draw_op_t           pend_op;
   logic [IDX_W-1:0]   pend_index;
   logic [COORD_W-1:0] pend_x0;
   logic [COORD_W-1:0] pend_y0;
   logic [COORD_W-1:0] pend_x1;
   logic [COORD_W-1:0] pend_y1;
   logic [COLOR_W-1:0] pend_color;
   logic               accept;
   logic               commit;

   // one slot only, so ready simply mirrors an empty slot
   assign cmd_ready = ~pend_valid;
   assign accept    = cmd_valid & cmd_ready;
   assign commit    = pend_valid & frame_start;

   // *******************************************************************
   // pending command slot
   // *******************************************************************

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pend_valid <= 1'b0;
      else if (accept)
         pend_valid <= 1'b1;
      else if (commit)
         pend_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         pend_op    <= cmd_op;
         pend_index <= cmd_index;
         pend_x0    <= cmd_x0;
         pend_y0    <= cmd_y0;
         pend_x1    <= cmd_x1;
         pend_y1    <= cmd_y1;
         pend_color <= cmd_color;
      end
   end

   // *******************************************************************
   // rectangle table, written only at the frame boundary
   // *******************************************************************

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rect_en  <= '0;
         bg_color <= '0;
      end
      else if (commit)
      begin
         case (pend_op)
            OP_SET_RECT:
               for (int i = 0; i < NUM_RECTS; i++)
                  if (pend_index == IDX_W'(i))
                     rect_en[i] <= 1'b1;
            OP_SET_BG:
               bg_color <= pend_color;
            OP_DISABLE_RECT:
               for (int i = 0; i < NUM_RECTS; i++)
                  if (pend_index == IDX_W'(i))
                     rect_en[i] <= 1'b0;
            default:
               ;
         endcase
      end
   end

   // an index past the table end matches no slot and is dropped
   always_ff @(posedge clk)
   begin
      if (commit && (pend_op == OP_SET_RECT))
      begin
         for (int i = 0; i < NUM_RECTS; i++)
         begin
            if (pend_index == IDX_W'(i))
            begin
               rect_x0[i]    <= pend_x0;
               rect_y0[i]    <= pend_y0;
               rect_x1[i]    <= pend_x1;
               rect_y1[i]    <= pend_y1;
               rect_color[i] <= pend_color;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/vga_sync.sv
`timescale 1ns/100ps
`default_nettype none

module vga_sync
   import vga_timing_pkg::*;
   #(
      parameter int H_DISPLAY = H_DISPLAY_640,
      parameter int H_FRONT   = H_FRONT_640,
      parameter int H_BACK    = H_BACK_640,
      parameter int H_RETRACE = H_RETRACE_640,
      parameter int V_DISPLAY = V_DISPLAY_480,
      parameter int V_FRONT   = V_FRONT_480,
      parameter int V_BACK    = V_BACK_480,
      parameter int V_RETRACE = V_RETRACE_480
   )
   (
      input  wire                clk,
      input  wire                reset,
      output logic               hsync_raw,
      output logic               vsync_raw,
      output logic               video_on,
      output logic               p_tick,
      output logic               frame_start,
      output logic [COORD_W-1:0] pixel_x,
      output logic [COORD_W-1:0] pixel_y
   );

   localparam logic [COORD_W-1:0] H_LAST  = COORD_W'(H_DISPLAY + H_FRONT + H_BACK + H_RETRACE - 1);
   localparam logic [COORD_W-1:0] V_LAST  = COORD_W'(V_DISPLAY + V_FRONT + V_BACK + V_RETRACE - 1);
   localparam logic [COORD_W-1:0] H_SYNC0 = COORD_W'(H_DISPLAY + H_FRONT);
   localparam logic [COORD_W-1:0] H_SYNC1 = COORD_W'(H_DISPLAY + H_FRONT + H_RETRACE);
   localparam logic [COORD_W-1:0] V_SYNC0 = COORD_W'(V_DISPLAY + V_FRONT);
   localparam logic [COORD_W-1:0] V_SYNC1 = COORD_W'(V_DISPLAY + V_FRONT + V_RETRACE);
   localparam logic [COORD_W-1:0] H_VIS   = COORD_W'(H_DISPLAY);
   localparam logic [COORD_W-1:0] V_VIS   = COORD_W'(V_DISPLAY);

   logic               tick_reg;
   logic [COORD_W-1:0] h_count;
   logic [COORD_W-1:0] v_count;
   logic               h_end;
   logic               v_end;

   assign h_end = (h_count == H_LAST);
   assign v_end = (v_count == V_LAST);

   // *******************************************************************
   // pixel tick and scan counters
   // *******************************************************************

   // tick is high on the first clock out of reset
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tick_reg  <= 1'b1;
         h_count   <= '0;
         v_count   <= '0;
         hsync_raw <= 1'b0;
         vsync_raw <= 1'b0;
      end
      else
      begin
         tick_reg <= ~tick_reg;
         if (tick_reg)
         begin
            if (h_end)
            begin
               h_count <= '0;
               if (v_end)
                  v_count <= '0;
               else
                  v_count <= v_count + 1'b1;
            end
            else
               h_count <= h_count + 1'b1;
         end
         // sync lags the counters by one clock
         hsync_raw <= (h_count >= H_SYNC0) && (h_count < H_SYNC1);
         vsync_raw <= (v_count >= V_SYNC0) && (v_count < V_SYNC1);
      end
   end

   assign video_on    = (h_count < H_VIS) && (v_count < V_VIS);
   // last tick of the frame, counters wrap to (0,0) on this edge
   assign frame_start = tick_reg & h_end & v_end;
   assign p_tick      = tick_reg;
   assign pixel_x     = h_count;
   assign pixel_y     = v_count;

endmodule

`default_nettype wire

//--- rtl/draw_pkg.sv
`default_nettype none

package draw_pkg;

   // *******************************************************************
   // colour format
   // *******************************************************************

   // rgb444, red in the top nibble
   localparam int COLOR_W = 12;

   // *******************************************************************
   // command set
   // *******************************************************************

   // set_rect writes corners and colour and enables the slot
   // set_bg only looks at the colour field
   // disable_rect only looks at the index field
   typedef enum logic [1:0]
   {
      OP_SET_RECT     = 2'd0,
      OP_SET_BG       = 2'd1,
      OP_DISABLE_RECT = 2'd2
   } draw_op_t;

   // size of the rectangle table unless the top level overrides it
   localparam int DEFAULT_NUM_RECTS = 4;

endpackage

`default_nettype wire

//--- rtl/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

   // *******************************************************************
   // scan coordinate width, wide enough for an 800 x 525 raster
   // *******************************************************************
   localparam int COORD_W = 10;

   // *******************************************************************
   // standard 640x480 timing, counted in pixel ticks and lines
   // *******************************************************************

   // horizontal
   localparam int H_DISPLAY_640 = 640;
   localparam int H_FRONT_640   = 16;
   localparam int H_BACK_640    = 48;
   localparam int H_RETRACE_640 = 96;

   // vertical
   localparam int V_DISPLAY_480 = 480;
   localparam int V_FRONT_480   = 10;
   localparam int V_BACK_480    = 33;
   localparam int V_RETRACE_480 = 2;

   // full raster is 800 x 525
   // the sync pulse sits after display and front porch in both directions

endpackage

`default_nettype wire
